/* include/rvCore_config.svh */
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

// RV32 datapath widths
`define XLEN        32          // data and address width
`define REG_ADDR_W  5           // x0..x31 index

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// base opcodes kept in this core
`define OP_LOAD     7'b0000011  // lw
`define OP_STORE    7'b0100011  // sw
`define OP_RTYPE    7'b0110011  // reg-reg ALU
`define OP_ITYPE    7'b0010011  // reg-imm ALU
`define OP_BRANCH   7'b1100011  // beq..bgeu
`define OP_JAL      7'b1101111  // jal

`endif

/* rtl/rvCorePkg.sv */
package rvCorePkg;

   // ALU function select
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,                      // signed less-than
      ALU_SLTU,                     // unsigned less-than
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } aluOp_t;

   typedef enum logic [1:0] {
      IMM_I,                        // loads, ALU immediates
      IMM_S,                        // stores
      IMM_B,                        // branches
      IMM_J                         // jal
   } immSrc_t;

   typedef enum logic [1:0] {
      RES_ALU,                      // ALU result
      RES_MEM,                      // load data
      RES_PC4                       // link address
   } resultSrc_t;

   // condition flags from the ALU adder
   typedef struct packed {
      logic zero;                   // result is all zeros
      logic negative;               // sum msb
      logic overflow;               // signed overflow
      logic carry;                  // no borrow on subtract
   } aluFlags_t;

   typedef struct packed {
      logic       regWrite;         // rd written at edge
      logic       memWrite;         // store commits
      logic       memStrobe;        // any data access
      logic       aluSrc;           // B operand from immediate
      logic       pcSrc;            // take branch target
      logic       pcEnable;         // PC advances
      immSrc_t    immSrc;
      resultSrc_t resultSrc;
      aluOp_t     aluOp;
   } ctrl_t;

endpackage

/* rtl/rvDecoder.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvDecoder
   import rvCorePkg::*;
(
   input  logic             reset,
   input  logic             pcReady,
   input  logic [`XLEN-1:0] instr,
   input  aluFlags_t        flags,
   output ctrl_t            ctrl
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7b5;
   logic       isRtype;
   logic       branch;                      // conditional branch opcode
   logic       jump;                        // jal
   logic       takeBranch;                  // condition met for funct3
   logic       retire;                      // instruction completes this cycle
   aluOp_t     aluFromFunct;
   ctrl_t      dec;                         // ungated main decode

   assign opcode   = instr[6:0];
   assign funct3   = instr[14:12];
   assign funct7b5 = instr[30];
   assign isRtype  = (opcode == `OP_RTYPE);

   // funct3 to ALU op for R and I types
   always_comb begin
      case (funct3)
         3'b000:  aluFromFunct = (isRtype && funct7b5) ? ALU_SUB : ALU_ADD; // addi never subtracts
         3'b001:  aluFromFunct = ALU_SLL;
         3'b010:  aluFromFunct = ALU_SLT;   // result from N^V of a subtract
         3'b011:  aluFromFunct = ALU_SLTU;  // result from inverted carry
         3'b100:  aluFromFunct = ALU_XOR;
         3'b101:  aluFromFunct = funct7b5 ? ALU_SRA : ALU_SRL; // srai shares funct7 bit
         3'b110:  aluFromFunct = ALU_OR;
         default: aluFromFunct = ALU_AND;   // 111
      endcase
   end

   // opcode to main control fields
   always_comb begin
      dec    = '0;                          // unknown opcodes do nothing
      branch = 1'b0;
      jump   = 1'b0;
      case (opcode)
         `OP_LOAD: begin
            dec.regWrite  = 1'b1;
            dec.memStrobe = 1'b1;
            dec.aluSrc    = 1'b1;           // base + offset
            dec.immSrc    = IMM_I;
            dec.resultSrc = RES_MEM;
            dec.aluOp     = ALU_ADD;
         end
         `OP_STORE: begin
            dec.memWrite  = 1'b1;
            dec.memStrobe = 1'b1;
            dec.aluSrc    = 1'b1;
            dec.immSrc    = IMM_S;
            dec.aluOp     = ALU_ADD;
         end
         `OP_RTYPE: begin
            dec.regWrite  = 1'b1;
            dec.aluOp     = aluFromFunct;
         end
         `OP_ITYPE: begin
            dec.regWrite  = 1'b1;
            dec.aluSrc    = 1'b1;
            dec.immSrc    = IMM_I;
            dec.aluOp     = aluFromFunct;
         end
         `OP_BRANCH: begin
            dec.immSrc    = IMM_B;
            dec.aluOp     = ALU_SUB;        // flags from rs1 - rs2
            branch        = 1'b1;
         end
         `OP_JAL: begin
            dec.regWrite  = 1'b1;
            dec.immSrc    = IMM_J;
            dec.resultSrc = RES_PC4;        // rd gets return address
            jump          = 1'b1;
         end
         default: ;
      endcase
   end

   // branch condition from subtract flags
   always_comb begin
      case (funct3)
         3'b000:  takeBranch = flags.zero;                           // beq
         3'b001:  takeBranch = ~flags.zero;                          // bne
         3'b100:  takeBranch = flags.negative ^ flags.overflow;      // blt
         3'b101:  takeBranch = ~(flags.negative ^ flags.overflow);   // bge
         3'b110:  takeBranch = ~flags.carry;                         // bltu, borrow
         3'b111:  takeBranch = flags.carry;                          // bgeu
         default: takeBranch = 1'b0;                                 // reserved
      endcase
   end

   assign retire = pcReady & ~reset;

   // stall and reset gating of the state-changing fields
   always_comb begin
      ctrl           = dec;
      ctrl.pcSrc     = (branch & takeBranch) | jump;
      ctrl.regWrite  = dec.regWrite & retire;
      ctrl.memWrite  = dec.memWrite & retire;
      ctrl.memStrobe = dec.memStrobe & ~reset;   // still follows instr while stalled
      ctrl.pcEnable  = retire;
   end

endmodule

/* rtl/rvFetch.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvFetch
   import rvCorePkg::*;
(
   input  logic             clk,
   input  logic             reset,
   input  ctrl_t            ctrl,
   input  logic [`XLEN-1:0] immExt,
   output logic [`XLEN-1:0] pc,
   output logic [`XLEN-1:0] pcPlus4
);

   localparam logic [`XLEN-1:0] pcStep = 4;    // one word per instruction

   logic [`XLEN-1:0] pcTarget;                 // branch or jal target
   logic [`XLEN-1:0] pcNext;

   assign pcPlus4  = pc + pcStep;
   assign pcTarget = pc + immExt;              // B and J offsets are pc relative
   assign pcNext   = ctrl.pcSrc ? pcTarget : pcPlus4;

   // holds while stalled, pcEnable low
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= `RESET_PC;
      end else if (ctrl.pcEnable) begin
         pc <= pcNext;
      end
   end

endmodule

/* rtl/rvRegFile.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvRegFile
   import rvCorePkg::*;
(
   input  logic             clk,
   input  ctrl_t            ctrl,
   input  logic [`XLEN-1:0] instr,
   input  logic [`XLEN-1:0] aluResult,
   input  logic [`XLEN-1:0] readData,
   input  logic [`XLEN-1:0] pcPlus4,
   output logic [`XLEN-1:0] rs1Data,
   output logic [`XLEN-1:0] rs2Data
);

   logic [`XLEN-1:0]      regs [2**`REG_ADDR_W];    // x0 entry never written
   logic [`REG_ADDR_W-1:0] rs1Adr;
   logic [`REG_ADDR_W-1:0] rs2Adr;
   logic [`REG_ADDR_W-1:0] rdAdr;
   logic [`XLEN-1:0]      wrData;                  // write-back value

   assign rs1Adr = instr[19:15];
   assign rs2Adr = instr[24:20];
   assign rdAdr  = instr[11:7];

   // write-back select
   always_comb begin
      case (ctrl.resultSrc)
         RES_MEM: wrData = readData;
         RES_PC4: wrData = pcPlus4;              // jal link
         default: wrData = aluResult;
      endcase
   end

   always_ff @(posedge clk) begin
      if (ctrl.regWrite && (rdAdr != '0)) begin
         regs[rdAdr] <= wrData;
      end
   end

   assign rs1Data = (rs1Adr == '0) ? '0 : regs[rs1Adr];   // x0 reads zero
   assign rs2Data = (rs2Adr == '0) ? '0 : regs[rs2Adr];

endmodule

/* rtl/rvImmExtend.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvImmExtend
   import rvCorePkg::*;
(
   input  logic [`XLEN-1:0] instr,
   input  ctrl_t            ctrl,
   output logic [`XLEN-1:0] immExt
);

   // sign bit is always instr[31]
   always_comb begin
      case (ctrl.immSrc)
         IMM_S:   immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         IMM_B:   immExt = {{20{instr[31]}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};                       // halfword offset
         IMM_J:   immExt = {{12{instr[31]}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};                      // jal reach +-1 MiB
         default: immExt = {{20{instr[31]}}, instr[31:20]};          // I type
      endcase
   end

endmodule

/* rtl/rvAlu.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvAlu
   import rvCorePkg::*;
(
   input  ctrl_t            ctrl,
   input  logic [`XLEN-1:0] rs1Data,
   input  logic [`XLEN-1:0] rs2Data,
   input  logic [`XLEN-1:0] immExt,
   output logic [`XLEN-1:0] result,
   output aluFlags_t        flags
);

   localparam int shamtW = $clog2(`XLEN);   // 5 for RV32

   logic [`XLEN-1:0]   srcB;
   logic [`XLEN-1:0]   bInv;                  // B or ~B for subtract
   logic [`XLEN:0]     sumExt;                // extra bit carries out
   logic [`XLEN-1:0]   sum;
   logic               doSub;
   logic [shamtW-1:0]  shamt;
   logic               lessSigned;
   logic               lessUnsigned;

   assign srcB   = ctrl.aluSrc ? immExt : rs2Data;
   assign doSub  = (ctrl.aluOp == ALU_SUB) || (ctrl.aluOp == ALU_SLT) ||
                   (ctrl.aluOp == ALU_SLTU);   // compares subtract too
   assign bInv   = doSub ? ~srcB : srcB;
   assign sumExt = {1'b0, rs1Data} + {1'b0, bInv} + {{`XLEN{1'b0}}, doSub};
   assign sum    = sumExt[`XLEN-1:0];
   assign shamt  = srcB[shamtW-1:0];

   assign flags.carry    = sumExt[`XLEN];     // set when no borrow
   assign flags.negative = sum[`XLEN-1];
   assign flags.overflow = ~(rs1Data[`XLEN-1] ^ bInv[`XLEN-1]) &
                           (rs1Data[`XLEN-1] ^ sum[`XLEN-1]);  // same-sign inputs, sign flipped
   assign flags.zero     = (result == '0);

   assign lessSigned   = flags.negative ^ flags.overflow;
   assign lessUnsigned = ~flags.carry;

   always_comb begin
      case (ctrl.aluOp)
         ALU_SUB:  result = sum;
         ALU_AND:  result = rs1Data & srcB;
         ALU_OR:   result = rs1Data | srcB;
         ALU_XOR:  result = rs1Data ^ srcB;
         ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lessSigned};
         ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
         ALU_SLL:  result = rs1Data << shamt;
         ALU_SRL:  result = rs1Data >> shamt;
         ALU_SRA:  result = $signed(rs1Data) >>> shamt;   // sign fill
         default:  result = sum;                          // add, address calc
      endcase
   end

endmodule

/* rtl/rvCore.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCore
   import rvCorePkg::*;
(
   input  logic             clk,
   input  logic             reset,
   input  logic [`XLEN-1:0] instr,
   input  logic [`XLEN-1:0] readData,
   input  logic             pcReady,      // low stalls the current instruction
   output logic [`XLEN-1:0] pc,
   output logic             memWrite,
   output logic             memStrobe,
   output logic [`XLEN-1:0] dataAdr,
   output logic [`XLEN-1:0] writeData
);

   ctrl_t            ctrl;
   aluFlags_t        flags;
   logic [`XLEN-1:0] immExt;
   logic [`XLEN-1:0] pcPlus4;
   logic [`XLEN-1:0] rs1Data;
   logic [`XLEN-1:0] rs2Data;

   assign memWrite  = ctrl.memWrite;        // already gated by pcReady
   assign memStrobe = ctrl.memStrobe;
   assign writeData = rs2Data;              // sw data straight from rs2

   rvDecoder decoder (
      .reset   (reset),
      .pcReady (pcReady),
      .instr   (instr),
      .flags   (flags),
      .ctrl    (ctrl)
   );

   rvFetch fetch (
      .clk     (clk),
      .reset   (reset),
      .ctrl    (ctrl),
      .immExt  (immExt),
      .pc      (pc),
      .pcPlus4 (pcPlus4)
   );

   rvRegFile regFile (
      .clk       (clk),
      .ctrl      (ctrl),
      .instr     (instr),
      .aluResult (dataAdr),                 // ALU result doubles as data address
      .readData  (readData),
      .pcPlus4   (pcPlus4),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data)
   );

   rvImmExtend immExtend (
      .instr  (instr),
      .ctrl   (ctrl),
      .immExt (immExt)
   );

   rvAlu alu (
      .ctrl    (ctrl),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .immExt  (immExt),
      .result  (dataAdr),
      .flags   (flags)
   );

endmodule

/* verification/rvCore_assert.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCore_assert (
   input logic             clk,
   input logic             reset,
   input logic             pcReady,
   input logic             memWrite,
   input logic             memStrobe,
   input logic [`XLEN-1:0] instr,
   input logic [`XLEN-1:0] pc
);

   int failCount = 0;                             // read by the testbench summary

   // bus quiet while in reset
   quietInReset: assert property (@(posedge clk) reset |-> !memWrite && !memStrobe)
      else begin
         failCount++;
         $error("memory access signaled while reset is high");
      end

   // pc sits at the reset vector one edge into reset
   pcInReset: assert property (@(posedge clk) reset |=> pc == `RESET_PC)
      else begin
         failCount++;
         $error("pc left the reset vector during reset");
      end

   // strobe on every lw and sw, stalled or not
   strobeOnAccess: assert property (@(posedge clk) disable iff (reset)
      memStrobe == (instr[6:0] == `OP_LOAD || instr[6:0] == `OP_STORE))
      else begin
         failCount++;
         $error("memStrobe does not follow the load and store opcodes");
      end

   stallHoldsPc: assert property (@(posedge clk) disable iff (reset) !pcReady |=> $stable(pc))
      else begin
         failCount++;
         $error("pc moved across a stalled cycle");
      end

   noStalledWrite: assert property (@(posedge clk) !pcReady |-> !memWrite)
      else begin
         failCount++;
         $error("store committed while pcReady was low");
      end

   pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else begin
         failCount++;
         $error("pc is not word aligned");
      end

endmodule

bind rvCore rvCore_assert checks (
   .clk       (clk),
   .reset     (reset),
   .pcReady   (pcReady),
   .memWrite  (memWrite),
   .memStrobe (memStrobe),
   .instr     (instr),
   .pc        (pc)
);

/* verification/rvCore_tb.sv */
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCore_tb;

   localparam int doneAdr   = 'h3FC;              // last store ends the program
   localparam int poisonAdr = 'h3F0;              // skipped stores aim here

   logic             clk = 1'b0;
   logic             reset = 1'b1;
   logic             pcReady = 1'b1;
   logic [`XLEN-1:0] instr;
   logic [`XLEN-1:0] readData;
   logic [`XLEN-1:0] pc;
   logic [`XLEN-1:0] dataAdr;
   logic [`XLEN-1:0] writeData;
   logic             memWrite;
   logic             memStrobe;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [31:0] xv [32];                          // register values per ISA rules
   logic [31:0] expAdr [$];
   logic [31:0] expData [$];
   int          expGroup [$];
   string       groupName [5] = '{"alu", "load-store", "branch", "jal", "done"};
   int          grpErr [5];
   int          grpStores [5];
   int          ptr;
   int          nextAdr;
   int          progLen;
   int          cycleLimit;
   int          cycles;
   int          stalls;
   int          errors;
   int          checked;
   integer      seed = 6;
   logic        doneSeen = 1'b0;
   logic        firstRetired;                     // pcReady at the first edge after reset

   rvCore uut (.*);

   assign instr    = imem[pc[9:2]];               // word addressed, 1 KiB each
   assign readData = dmem[dataAdr[9:2]];

   initial begin
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] modelAlu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
      logic [31:0] r;
      case (f3)
         3'b000:  r = alt ? a - b : a + b;
         3'b001:  r = a << b[4:0];
         3'b010:  r = {31'b0, $signed(a) < $signed(b)};
         3'b011:  r = {31'b0, a < b};
         3'b100:  r = a ^ b;
         3'b101: begin
            if (alt)
               r = $signed(a) >>> b[4:0];         // arithmetic, sign fill
            else
               r = a >> b[4:0];
         end
         3'b110:  r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic conditionHolds(input logic [2:0] f3, input logic [31:0] a,
                                           input logic [31:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic emit(input logic [31:0] w);
      imem[ptr] = w;
      ptr++;
   endtask

   task automatic storeWord(input logic [4:0] rs, input int adr);  // sw rs, adr(x0)
      logic [11:0] off;
      off = adr[11:0];
      emit({off[11:5], rs, 5'd0, 3'b010, off[4:0], `OP_STORE});
   endtask

   task automatic expectStore(input logic [4:0] rs, input int group);
      storeWord(rs, nextAdr);
      expAdr.push_back(nextAdr);
      expData.push_back(xv[rs]);
      expGroup.push_back(group);
      nextAdr += 4;
   endtask

   task automatic setReg(input logic [4:0] rd, input int imm);   // addi rd, x0, imm
      emit({imm[11:0], 5'd0, 3'b000, rd, `OP_ITYPE});
      if (rd != 0)
         xv[rd] = {{20{imm[11]}}, imm[11:0]};
   endtask

   task automatic aluCase(input logic isImm, input logic [2:0] f3, input logic alt,
                          input logic [4:0] rs1, input logic [4:0] rs2, input int imm);
      logic [11:0] f;
      logic [31:0] b;
      f = imm[11:0];
      if (isImm) begin
         b = {{20{f[11]}}, f};
         if (alt)
            f[10] = 1'b1;                         // srai marker bit
         emit({f, rs1, f3, 5'd10, `OP_ITYPE});
      end else begin
         b = xv[rs2];
         emit({1'b0, alt, 5'd0, rs2, rs1, f3, 5'd10, `OP_RTYPE});
      end
      xv[10] = modelAlu(f3, alt, xv[rs1], b);
      expectStore(5'd10, 0);
   endtask

   // branch +8 over one store, poison if taken, marker if not
   task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
      emit({1'b0, 6'd0, rs2, rs1, f3, 4'b0100, 1'b0, `OP_BRANCH});
      if (conditionHolds(f3, xv[rs1], xv[rs2]))
         storeWord(5'd1, poisonAdr);
      else
         expectStore(5'd2, 2);
   endtask

   task automatic loadProgram();
      int lwAdr;
      foreach (imem[i])
         imem[i] = '0;                            // zero word is no operation
      foreach (dmem[i])
         dmem[i] = '0;
      xv[0]   = '0;
      ptr     = 0;
      nextAdr = 'h100;
      setReg(1, -8);
      setReg(2, 3);
      setReg(3, 31);
      emit({12'd31, 5'd2, 3'b001, 5'd4, `OP_ITYPE});   // slli x4, x2, 31
      xv[4] = xv[2] << 31;
      aluCase(0, 3'b000, 0, 1, 2, 0);             // add
      aluCase(0, 3'b000, 1, 4, 2, 0);             // sub with signed overflow
      aluCase(0, 3'b001, 0, 2, 3, 0);             // sll by 31
      aluCase(0, 3'b010, 0, 1, 2, 0);
      aluCase(0, 3'b011, 0, 1, 2, 0);             // -8 is large unsigned
      aluCase(0, 3'b100, 0, 1, 2, 0);
      aluCase(0, 3'b101, 0, 1, 3, 0);             // srl by 31
      aluCase(0, 3'b101, 1, 1, 3, 0);             // sra by 31
      aluCase(0, 3'b110, 0, 1, 2, 0);
      aluCase(0, 3'b111, 0, 4, 1, 0);
      aluCase(1, 3'b000, 0, 1, 0, -1);
      aluCase(1, 3'b010, 0, 1, 0, -7);
      aluCase(1, 3'b011, 0, 2, 0, -1);            // compares against all ones
      aluCase(1, 3'b100, 0, 1, 0, -1);            // bitwise not
      aluCase(1, 3'b110, 0, 2, 0, 'h7F0);
      aluCase(1, 3'b111, 0, 1, 0, 'h0F0);
      aluCase(1, 3'b001, 0, 1, 0, 31);
      aluCase(1, 3'b101, 0, 1, 0, 31);
      aluCase(1, 3'b101, 1, 1, 0, 31);
      lwAdr = nextAdr;
      expectStore(5'd1, 1);
      emit({lwAdr[11:0], 5'd0, 3'b010, 5'd6, `OP_LOAD});   // lw x6 back
      xv[6] = xv[1];
      emit({12'd1, 5'd6, 3'b000, 5'd6, `OP_ITYPE});
      xv[6] = xv[6] + 1;
      expectStore(5'd6, 1);
      setReg(0, 5);                               // x0 drops the write
      expectStore(5'd0, 1);
      branchCase(3'b000, 2, 2);
      branchCase(3'b000, 1, 2);
      branchCase(3'b001, 1, 2);
      branchCase(3'b001, 2, 2);
      branchCase(3'b100, 4, 2);                   // subtract overflows
      branchCase(3'b100, 2, 1);
      branchCase(3'b101, 2, 4);
      branchCase(3'b101, 1, 2);
      branchCase(3'b110, 2, 1);
      branchCase(3'b110, 1, 2);
      branchCase(3'b111, 1, 2);
      branchCase(3'b111, 2, 1);
      xv[7] = ptr * 4 + 4;                        // link of the jal below
      emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, `OP_JAL});   // jal x7, +8
      storeWord(5'd1, poisonAdr);
      expectStore(5'd7, 3);
      storeWord(5'd2, doneAdr);
      expAdr.push_back(doneAdr);
      expData.push_back(xv[2]);
      expGroup.push_back(4);
      emit({20'd0, 5'd0, `OP_JAL});               // jal x0, 0 parks the core
      progLen = ptr;
   endtask

   task automatic checkStore(input logic [31:0] adr, input logic [31:0] data);
      int g;
      assert (expAdr.size() > 0) else begin
         errors++;
         $display("Error at %0t: store of %h to %h came after the last expected store",
                  $time, data, adr);
      end
      if (expAdr.size() > 0) begin
         g = expGroup.pop_front();
         checked++;
         grpStores[g]++;
         assert (adr == expAdr[0] && data == expData[0]) else begin
            errors++;
            grpErr[g]++;
            $display("Mismatch at %0t: %s store wrote %h to %h, expected %h to %h",
                     $time, groupName[g], data, adr, expData[0], expAdr[0]);
         end
         void'(expAdr.pop_front());
         void'(expData.pop_front());
         if (expGroup.size() == 0 || expGroup[0] != g)
            $display("test %s finished: %0d stores, %0d errors",
                     groupName[g], grpStores[g], grpErr[g]);
      end
      if (adr == doneAdr)
         doneSeen = 1'b1;
   endtask

   always @(negedge clk) begin
      pcReady <= ($random(seed) % 4) != 0;        // about one stall in four
   end

   always @(posedge clk) begin
      cycles++;
      if (!reset && !pcReady)
         stalls++;
      if (memWrite) begin                         // only retiring stores reach here
         dmem[dataAdr[9:2]] <= writeData;
         checkStore(dataAdr, writeData);
      end
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         $display("timeout: the program did not reach the done store within %0d cycles",
                  cycleLimit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      loadProgram();
      cycleLimit = 4 * progLen + 100;             // stalls can double the run, plus reset
      repeat (10) begin
         @(negedge clk);
         assert (pc == `RESET_PC && !memWrite && !memStrobe) else begin
            errors++;
            $display("Mismatch at %0t: pc %h or data strobes active during reset", $time, pc);
         end
      end
      reset = 1'b0;
      @(posedge clk);
      firstRetired = pcReady;                     // first instruction leaves only if ready
      @(negedge clk);
      assert (pc == (firstRetired ? `RESET_PC + 4 : `RESET_PC)) else begin
         errors++;
         $display("Mismatch at %0t: pc %h after the first fetch, which should be at %h",
                  $time, pc, `RESET_PC);
      end
      $display("test reset finished: %0d errors", errors);
      wait (doneSeen);
      @(negedge clk);
      assert (stalls > 0) else begin
         errors++;
         $display("Error at %0t: pcReady never went low, so no stall was exercised", $time);
      end
      $display("test stall finished: %0d stalled cycles", stalls);
      $display("summary: %0d stores checked, %0d errors, %0d assertion failures, %0d cycles",
               checked, errors, uut.checks.failCount, cycles);
      if (errors == 0 && uut.checks.failCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
rtl/rvCorePkg.sv
rtl/rvDecoder.sv
rtl/rvFetch.sv
rtl/rvRegFile.sv
rtl/rvImmExtend.sv
rtl/rvAlu.sv
rtl/rvCore.sv
verification/rvCore_assert.sv
verification/rvCore_tb.sv

/* Bender.yml */
package:
  name: rvCore

export_include_dirs:
  - include

sources:
  - rtl/rvCorePkg.sv
  - rtl/rvDecoder.sv
  - rtl/rvFetch.sv
  - rtl/rvRegFile.sv
  - rtl/rvImmExtend.sv
  - rtl/rvAlu.sv
  - rtl/rvCore.sv
  - target: test
    files:
      - verification/rvCore_assert.sv
      - verification/rvCore_tb.sv
